/* design/exOpsPkg.sv */
// Execute stage operation codes, branch conditions and result-source encoding
`default_nettype none

package exOpsPkg;

    // ------------------------------------------------------------
    // Datapath sizing
    // ------------------------------------------------------------
    localparam int dataWidth  = 32;
    localparam int shiftWidth = $clog2(dataWidth);

    // ------------------------------------------------------------
    // SPECIAL function codes, ALU group
    // ------------------------------------------------------------
    localparam logic [5:0] funcSll   = 6'h00;
    localparam logic [5:0] funcSrl   = 6'h02;
    localparam logic [5:0] funcSra   = 6'h03;
    localparam logic [5:0] funcAdd   = 6'h20;
    localparam logic [5:0] funcAddu  = 6'h21;
    localparam logic [5:0] funcSub   = 6'h22;
    localparam logic [5:0] funcSubu  = 6'h23;
    localparam logic [5:0] funcAnd   = 6'h24;
    localparam logic [5:0] funcOr    = 6'h25;
    localparam logic [5:0] funcXor   = 6'h26;
    localparam logic [5:0] funcNor   = 6'h27;
    localparam logic [5:0] funcSlt   = 6'h2a;
    localparam logic [5:0] funcSltu  = 6'h2b;

    // SPECIAL function codes touching HI/LO
    localparam logic [5:0] funcMfhi  = 6'h10;
    localparam logic [5:0] funcMthi  = 6'h11;
    localparam logic [5:0] funcMflo  = 6'h12;
    localparam logic [5:0] funcMtlo  = 6'h13;
    localparam logic [5:0] funcMult  = 6'h18;
    localparam logic [5:0] funcMultu = 6'h19;

    // SPECIAL2 codes, only meaningful with mulOp set
    localparam logic [5:0] funcMadd  = 6'h00;
    localparam logic [5:0] funcMaddu = 6'h01;
    localparam logic [5:0] funcMul   = 6'h02;
    localparam logic [5:0] funcMsub  = 6'h04;
    localparam logic [5:0] funcMsubu = 6'h05;
    localparam logic [5:0] funcClz   = 6'h20;
    localparam logic [5:0] funcClo   = 6'h21;

    // ------------------------------------------------------------
    // Branch conditions and result sources
    // ------------------------------------------------------------
    typedef enum logic [2:0] {
        brEq  = 3'd0,
        brNe  = 3'd1,
        brLez = 3'd2,
        brGtz = 3'd3,
        brLtz = 3'd4,
        brGez = 3'd5
    } brCondE;

    typedef enum logic [1:0] {
        outAlu = 2'b00,
        outBra = 2'b01,
        outMul = 2'b10
    } outSelE;

endpackage

`default_nettype wire

/* design/exTypesPkg.sv */
// Execute stage payload and control structs shared between blocks
`default_nettype none

package exTypesPkg;

    // ------------------------------------------------------------
    // Issued request, as it enters the execute stage
    // ------------------------------------------------------------
    typedef struct packed {
        logic                                aluOp;
        logic                                mulOp;
        logic                                jump;
        logic                                branch;
        logic                                regWrite;
        logic                                aluEn;
        logic                                memWrite;
        logic [5:0]                          func;
        exOpsPkg::brCondE                    brCond;
        logic [exOpsPkg::dataWidth-1:0]      opA;
        logic [exOpsPkg::dataWidth-1:0]      opB;
        logic [exOpsPkg::dataWidth-1:0]      pc;
        logic [exOpsPkg::dataWidth-1:0]      imm;
        logic [4:0]                          destReg;
    } exRequestT;

    // ------------------------------------------------------------
    // One result per request, out of the stage
    // ------------------------------------------------------------
    typedef struct packed {
        logic [exOpsPkg::dataWidth-1:0]      value;
        logic                                regWrite;
        logic                                branchTaken;
        logic [exOpsPkg::dataWidth-1:0]      target;
        logic [4:0]                          destReg;
    } exResultT;

    // ------------------------------------------------------------
    // Decoded controls for the units and result mux
    // ------------------------------------------------------------
    typedef struct packed {
        // Accumulator write enable
        logic                                accEn;
        // Multiplier B source, low means constant one
        logic                                mulSelB;
        logic                                regWrite;
        logic                                braEn;
        logic                                branchTaken;
        exOpsPkg::outSelE                    outSel;
    } exCtrlT;

endpackage

`default_nettype wire

/* design/pipeStage.sv */
// One-entry elastic valid/ready register for any payload type
`timescale 1ns/1ps
`default_nettype none

module pipeStage #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    inValid,
    output logic    inReady,
    input  payloadT inData,
    output logic    outValid,
    input  logic    outReady,
    output payloadT outData
);

    logic    full;
    payloadT held;

    // Room when empty, or when the held item leaves this edge
    assign inReady  = !full || outReady;
    assign outValid = full;
    assign outData  = held;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            full <= 1'b0;
        end
        else if (inValid && inReady)
        begin
            full <= 1'b1;
        end
        else if (outReady)
        begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (inValid && inReady)
        begin
            held <= inData;
        end
    end

endmodule

`default_nettype wire

/* design/exControl.sv */
// Execute control decoding request class flags into unit selects and write enables
`timescale 1ns/1ps
`default_nettype none

module exControl (
    input  exTypesPkg::exRequestT req,
    input  logic                  braTaken,
    output exTypesPkg::exCtrlT    ctrl
);

    always_comb
    begin
        // Defaults: ALU result, pass regWrite, no accumulator update
        ctrl.accEn       = 1'b0;
        ctrl.mulSelB     = 1'b1;
        ctrl.regWrite    = req.regWrite;
        ctrl.braEn       = req.jump | req.branch;
        ctrl.branchTaken = 1'b0;
        ctrl.outSel      = exOpsPkg::outAlu;

        // ------------------------------------------------------------
        // SPECIAL group
        // ------------------------------------------------------------
        if (req.aluOp)
        begin
            case (req.func)
                exOpsPkg::funcMult,
                exOpsPkg::funcMultu,
                exOpsPkg::funcMfhi,
                exOpsPkg::funcMflo:
                begin
                    ctrl.accEn  = 1'b1;
                    ctrl.outSel = exOpsPkg::outMul;
                end
                exOpsPkg::funcMthi,
                exOpsPkg::funcMtlo:
                begin
                    // Operand A goes through the multiplier untouched
                    ctrl.mulSelB = 1'b0;
                    ctrl.accEn   = 1'b1;
                    ctrl.outSel  = exOpsPkg::outMul;
                end
                default:
                begin
                    ctrl.outSel   = exOpsPkg::outAlu;
                    ctrl.regWrite = req.aluEn & !req.memWrite;
                end
            endcase
        end

        // ------------------------------------------------------------
        // SPECIAL2 group
        // ------------------------------------------------------------
        if (req.mulOp)
        begin
            ctrl.outSel = exOpsPkg::outMul;
            case (req.func)
                // Result only, HI/LO untouched
                exOpsPkg::funcClz,
                exOpsPkg::funcClo,
                exOpsPkg::funcMul:
                begin
                    ctrl.accEn = 1'b0;
                end
                default:
                begin
                    ctrl.accEn = 1'b1;
                end
            endcase
        end

        // Control transfer wins over everything above
        if (req.jump)
        begin
            ctrl.regWrite    = req.regWrite;
            ctrl.branchTaken = 1'b1;
            ctrl.outSel      = exOpsPkg::outBra;
        end
        else if (req.branch)
        begin
            ctrl.regWrite    = req.regWrite & braTaken;
            ctrl.branchTaken = braTaken;
            ctrl.outSel      = exOpsPkg::outBra;
        end
    end

endmodule

`default_nettype wire

/* design/exAlu.sv */
// Integer ALU for add, subtract, logic, set-less-than and shifts
`timescale 1ns/1ps
`default_nettype none

module exAlu (
    input  logic [exOpsPkg::dataWidth-1:0] opA,
    input  logic [exOpsPkg::dataWidth-1:0] opB,
    input  logic [5:0]                     func,
    output logic [exOpsPkg::dataWidth-1:0] value
);

    logic [exOpsPkg::dataWidth-1:0]  sum;
    logic [exOpsPkg::dataWidth-1:0]  diff;
    logic [exOpsPkg::shiftWidth-1:0] shamt;
    logic                            lessSigned;
    logic                            lessUnsigned;

    assign sum          = opA + opB;
    assign diff         = opA - opB;
    // Shift amount from the low bits of A, applied to B
    assign shamt        = opA[exOpsPkg::shiftWidth-1:0];
    assign lessSigned   = $signed(opA) < $signed(opB);
    assign lessUnsigned = opA < opB;

    always_comb
    begin
        case (func)
            // No overflow trap, ADD acts as ADDU
            exOpsPkg::funcAdd,
            exOpsPkg::funcAddu: value = sum;
            exOpsPkg::funcSub,
            exOpsPkg::funcSubu: value = diff;
            exOpsPkg::funcAnd:  value = opA & opB;
            exOpsPkg::funcOr:   value = opA | opB;
            exOpsPkg::funcXor:  value = opA ^ opB;
            exOpsPkg::funcNor:  value = ~(opA | opB);
            exOpsPkg::funcSlt:
            begin
                value = {{(exOpsPkg::dataWidth-1){1'b0}}, lessSigned};
            end
            exOpsPkg::funcSltu:
            begin
                value = {{(exOpsPkg::dataWidth-1){1'b0}}, lessUnsigned};
            end
            exOpsPkg::funcSll:  value = opB << shamt;
            exOpsPkg::funcSrl:  value = opB >> shamt;
            exOpsPkg::funcSra:  value = $signed(opB) >>> shamt;
            // Unknown codes give the sum, which is the store address
            default:            value = sum;
        endcase
    end

endmodule

`default_nettype wire

/* design/exMulAcc.sv */
// Multiply/accumulate unit holding HI/LO, with MUL and leading zero/one count
`timescale 1ns/1ps
`default_nettype none

module exMulAcc (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic                           commit,
    input  exTypesPkg::exCtrlT             ctrl,
    input  logic [5:0]                     func,
    input  logic [exOpsPkg::dataWidth-1:0] opA,
    input  logic [exOpsPkg::dataWidth-1:0] opB,
    output logic [exOpsPkg::dataWidth-1:0] value
);

    localparam int dw = exOpsPkg::dataWidth;

    logic [dw-1:0]          hi;
    logic [dw-1:0]          lo;
    logic [dw-1:0]          mulB;
    logic signed [dw-1:0]   aSigned;
    logic signed [dw-1:0]   bSigned;
    logic signed [2*dw-1:0] prodS;
    logic [2*dw-1:0]        prodU;
    logic [2*dw-1:0]        accNext;

    // Leading count of bitVal from the MSB down
    function automatic logic [dw-1:0] leadCount(input logic [dw-1:0] w, input logic bitVal);
        logic [dw-1:0] n;
        logic          done;
        n    = '0;
        done = 1'b0;
        for (int i = dw - 1; i >= 0; i--)
        begin
            if (!done && w[i] == bitVal)
            begin
                n = n + 1'b1;
            end
            else
            begin
                done = 1'b1;
            end
        end
        return n;
    endfunction

    // B forced to one for MTHI/MTLO so the product is opA
    assign mulB    = ctrl.mulSelB ? opB : dw'(1);
    assign aSigned = opA;
    assign bSigned = mulB;
    assign prodS   = aSigned * bSigned;
    assign prodU   = {{dw{1'b0}}, opA} * {{dw{1'b0}}, mulB};

    // ------------------------------------------------------------
    // Result read path
    // ------------------------------------------------------------
    always_comb
    begin
        case (func)
            exOpsPkg::funcMfhi: value = hi;
            exOpsPkg::funcMflo: value = lo;
            exOpsPkg::funcMul:  value = prodS[dw-1:0];
            exOpsPkg::funcClz:  value = leadCount(opA, 1'b0);
            exOpsPkg::funcClo:  value = leadCount(opA, 1'b1);
            default:            value = lo;
        endcase
    end

    // ------------------------------------------------------------
    // Accumulator update
    // ------------------------------------------------------------
    always_comb
    begin
        accNext = {hi, lo};
        case (func)
            exOpsPkg::funcMult:  accNext = prodS;
            exOpsPkg::funcMultu: accNext = prodU;
            exOpsPkg::funcMadd:  accNext = {hi, lo} + prodS;
            exOpsPkg::funcMaddu: accNext = {hi, lo} + prodU;
            exOpsPkg::funcMsub:  accNext = {hi, lo} - prodS;
            exOpsPkg::funcMsubu: accNext = {hi, lo} - prodU;
            exOpsPkg::funcMthi:  accNext = {prodU[dw-1:0], lo};
            exOpsPkg::funcMtlo:  accNext = {hi, prodU[dw-1:0]};
            // MFHI/MFLO keep HI/LO as is
            default:             accNext = {hi, lo};
        endcase
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            hi <= '0;
            lo <= '0;
        end
        else if (commit && ctrl.accEn)
        begin
            {hi, lo} <= accNext;
        end
    end

endmodule

`default_nettype wire

/* design/exBranch.sv */
// Branch condition evaluation and branch/jump target computation
`timescale 1ns/1ps
`default_nettype none

module exBranch (
    input  exTypesPkg::exRequestT          req,
    output logic                           braTaken,
    output logic [exOpsPkg::dataWidth-1:0] target
);

    logic signed [exOpsPkg::dataWidth-1:0] aSigned;
    logic                                  condMet;
    logic [exOpsPkg::dataWidth-1:0]        branchTarget;

    assign aSigned = req.opA;

    always_comb
    begin
        case (req.brCond)
            exOpsPkg::brEq:  condMet = req.opA == req.opB;
            exOpsPkg::brNe:  condMet = req.opA != req.opB;
            // Sign tests look at A alone
            exOpsPkg::brLez: condMet = aSigned <= 0;
            exOpsPkg::brGtz: condMet = aSigned > 0;
            exOpsPkg::brLtz: condMet = aSigned < 0;
            exOpsPkg::brGez: condMet = aSigned >= 0;
            default:         condMet = 1'b0;
        endcase
    end

    assign braTaken = req.branch && condMet;

    // Word offset relative to the delay slot
    assign branchTarget = req.pc + exOpsPkg::dataWidth'(4) + (req.imm << 2);

    // Register jump takes its target from A
    assign target = req.jump ? req.opA : branchTarget;

endmodule

`default_nettype wire

/* design/exStage.sv */
// Execute stage top with registered input and output slots around the units
`timescale 1ns/1ps
`default_nettype none

module exStage (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  inValid,
    output logic                  inReady,
    input  exTypesPkg::exRequestT inReq,
    output logic                  outValid,
    input  logic                  outReady,
    output exTypesPkg::exResultT  outRes
);

    exTypesPkg::exRequestT          heldReq;
    exTypesPkg::exCtrlT             ctrl;
    exTypesPkg::exResultT           result;
    logic                           heldValid;
    logic                           outSlotReady;
    logic                           commit;
    logic                           braTaken;
    logic [exOpsPkg::dataWidth-1:0] braTarget;
    logic [exOpsPkg::dataWidth-1:0] aluValue;
    logic [exOpsPkg::dataWidth-1:0] mulValue;
    logic [exOpsPkg::dataWidth-1:0] linkAddr;
    logic [exOpsPkg::dataWidth-1:0] resValue;

    pipeStage #(.payloadT(exTypesPkg::exRequestT)) inSlot (
        .clk(clk), .arstN(arstN),
        .inValid(inValid), .inReady(inReady), .inData(inReq),
        .outValid(heldValid), .outReady(outSlotReady), .outData(heldReq)
    );

    // ------------------------------------------------------------
    // Combinational execute between the slots
    // ------------------------------------------------------------
    exBranch branchUnit (.req(heldReq), .braTaken(braTaken), .target(braTarget));

    exControl control (.req(heldReq), .braTaken(braTaken), .ctrl(ctrl));

    exAlu alu (.opA(heldReq.opA), .opB(heldReq.opB), .func(heldReq.func), .value(aluValue));

    // HI/LO moves only when the request hands over to outSlot
    assign commit = heldValid && outSlotReady;

    exMulAcc mulAcc (
        .clk(clk), .arstN(arstN), .commit(commit), .ctrl(ctrl),
        .func(heldReq.func), .opA(heldReq.opA), .opB(heldReq.opB), .value(mulValue)
    );

    // Link address for jumps and branches
    assign linkAddr = heldReq.pc + exOpsPkg::dataWidth'(8);

    always_comb
    begin
        case (ctrl.outSel)
            exOpsPkg::outBra: resValue = linkAddr;
            exOpsPkg::outMul: resValue = mulValue;
            default:          resValue = aluValue;
        endcase
    end

    assign result.value       = resValue;
    assign result.regWrite    = ctrl.regWrite;
    assign result.branchTaken = ctrl.branchTaken;
    assign result.target      = ctrl.braEn ? braTarget : '0;
    assign result.destReg     = heldReq.destReg;

    pipeStage #(.payloadT(exTypesPkg::exResultT)) outSlot (
        .clk(clk), .arstN(arstN),
        .inValid(heldValid), .inReady(outSlotReady), .inData(result),
        .outValid(outValid), .outReady(outReady), .outData(outRes)
    );

endmodule

`default_nettype wire

/* bench/exStage_asserts.sv */
// Handshake, reset, accumulator and branch-link checks bound into the execute stage
`timescale 1ns/1ps
`default_nettype none

module exStageAsserts (
    input logic                           clk,
    input logic                           arstN,
    input logic                           outValid,
    input logic                           outReady,
    input exTypesPkg::exResultT           outRes,
    input logic                           heldValid,
    input exTypesPkg::exRequestT          heldReq,
    input logic                           braTaken,
    input exTypesPkg::exCtrlT             ctrl,
    input logic [exOpsPkg::dataWidth-1:0] hi,
    input logic [exOpsPkg::dataWidth-1:0] lo
);

    resetQuiet: assert property (@(posedge clk) !arstN |-> !outValid)
        else $error("outValid high while reset is held");

    // Offered result stays put until taken
    holdUnderStall: assert property (@(posedge clk) disable iff (!arstN)
        outValid && !outReady |=> outValid && $stable(outRes))
        else $error("outRes or outValid changed under stall");

    // Nothing leaving inSlot, or outSlot stalled, leaves HI/LO alone
    accHeld: assert property (@(posedge clk) disable iff (!arstN)
        (!heldValid || (outValid && !outReady)) |=> $stable(hi) && $stable(lo))
        else $error("HI/LO changed while no request was leaving the stage");

    noLinkWhenNotTaken: assert property (@(posedge clk) disable iff (!arstN)
        heldValid && heldReq.branch && !braTaken |-> !ctrl.regWrite)
        else $error("Non-taken branch asked for a register write");

endmodule

bind exStage exStageAsserts handshakeChecks (
    .clk(clk), .arstN(arstN), .outValid(outValid), .outReady(outReady), .outRes(outRes),
    .heldValid(heldValid), .heldReq(heldReq), .braTaken(braTaken),
    .ctrl(ctrl), .hi(mulAcc.hi), .lo(mulAcc.lo)
);

`default_nettype wire

/* bench/exStageTb.sv */
// Execute stage testbench that streams a request table through random output stalls
`timescale 1ns/1ps
`default_nettype none

module exStageTb;

    localparam int waitLimit = 100;
    localparam logic [5:0] funcNone = 6'h3f;

    // Flag groups {aluOp, mulOp, jump, branch, regWrite, aluEn, memWrite}
    localparam logic [6:0] aluRw    = 7'b1000110;
    localparam logic [6:0] aluStore = 7'b1000111;
    localparam logic [6:0] hiloRead = 7'b1000100;
    localparam logic [6:0] hiloSet  = 7'b1000000;
    localparam logic [6:0] mulRead  = 7'b0100100;
    localparam logic [6:0] mulAccum = 7'b0100000;
    localparam logic [6:0] brPlain  = 7'b0001000;
    localparam logic [6:0] brLink   = 7'b0001100;
    localparam logic [6:0] jmpLink  = 7'b0010100;
    localparam logic [6:0] jmpPlain = 7'b0010000;

    logic                  clk;
    logic                  arstN;
    logic                  inValid;
    logic                  inReady;
    exTypesPkg::exRequestT inReq;
    logic                  outValid;
    logic                  outReady;
    exTypesPkg::exResultT  outRes;

    exTypesPkg::exRequestT reqTab[$];
    exTypesPkg::exResultT  expTab[$];
    string                 nameTab[$];
    int                    driveWait;
    int                    collectWait;
    logic                  gotIt;

    exStage dut (
        .clk(clk), .arstN(arstN),
        .inValid(inValid), .inReady(inReady), .inReq(inReq),
        .outValid(outValid), .outReady(outReady), .outRes(outRes)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic stopWithFailure(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    // ------------------------------------------------------------
    // Table building
    // ------------------------------------------------------------
    task automatic addEntry(input string name, input logic [6:0] flags, input logic [5:0] func,
                            input exOpsPkg::brCondE cond, input logic [31:0] a,
                            input logic [31:0] b, input logic [31:0] pc, input logic [31:0] imm,
                            input logic [31:0] expValue, input logic expRw,
                            input logic expTaken, input logic [31:0] expTarget);
        exTypesPkg::exRequestT req;
        exTypesPkg::exResultT  res;
        logic [4:0]            dest;
        // Destination tag follows the entry index
        dest = 5'(nameTab.size());
        req  = {flags, func, cond, a, b, pc, imm, dest};
        res  = {expValue, expRw, expTaken, expTarget, dest};
        reqTab.push_back(req);
        expTab.push_back(res);
        nameTab.push_back(name);
    endtask

    // Non-branch operation that is never taken and has no target
    task automatic addOp(input string name, input logic [6:0] flags, input logic [5:0] func,
                         input logic [31:0] a, input logic [31:0] b,
                         input logic [31:0] expValue, input logic expRw);
        addEntry(name, flags, func, exOpsPkg::brEq, a, b, 32'h0, 32'h0,
                 expValue, expRw, 1'b0, 32'h0);
    endtask

    task automatic addBranch(input string name, input logic [6:0] flags,
                             input exOpsPkg::brCondE cond, input logic [31:0] a,
                             input logic [31:0] b, input logic [31:0] pc, input logic [31:0] imm,
                             input logic [31:0] expValue, input logic expRw,
                             input logic expTaken, input logic [31:0] expTarget);
        addEntry(name, flags, funcNone, cond, a, b, pc, imm, expValue, expRw, expTaken, expTarget);
    endtask

    task automatic buildTable();
        // ALU results
        addOp("addu", aluRw, exOpsPkg::funcAddu, 32'h5, 32'h7, 32'hc, 1'b1);
        addOp("add wraps", aluRw, exOpsPkg::funcAdd, 32'hffffffff, 32'h1, 32'h0, 1'b1);
        addOp("sub", aluRw, exOpsPkg::funcSub, 32'ha, 32'h3, 32'h7, 1'b1);
        addOp("subu", aluRw, exOpsPkg::funcSubu, 32'h3, 32'ha, 32'hfffffff9, 1'b1);
        addOp("and", aluRw, exOpsPkg::funcAnd, 32'hff00ff00, 32'h0ff00ff0, 32'h0f000f00, 1'b1);
        addOp("xor", aluRw, exOpsPkg::funcXor, 32'hff00ff00, 32'h0ff00ff0, 32'hf0f0f0f0, 1'b1);
        addOp("nor", aluRw, exOpsPkg::funcNor, 32'hff00ff00, 32'h0ff00ff0, 32'h000f000f, 1'b1);
        addOp("slt", aluRw, exOpsPkg::funcSlt, 32'hffffffff, 32'h1, 32'h1, 1'b1);
        addOp("sltu", aluRw, exOpsPkg::funcSltu, 32'hffffffff, 32'h1, 32'h0, 1'b1);
        addOp("sll", aluRw, exOpsPkg::funcSll, 32'h4, 32'h1, 32'h10, 1'b1);
        addOp("srl", aluRw, exOpsPkg::funcSrl, 32'h4, 32'h80000000, 32'h08000000, 1'b1);
        addOp("sra", aluRw, exOpsPkg::funcSra, 32'h4, 32'h80000000, 32'hf8000000, 1'b1);
        addOp("store address", aluStore, funcNone, 32'h1000, 32'h24, 32'h1024, 1'b0);
        // Multiply into HI/LO returns the LO seen before the update
        addOp("mult", hiloSet, exOpsPkg::funcMult, 32'hfffffffe, 32'h3, 32'h0, 1'b0);
        addOp("mfhi after mult", hiloRead, exOpsPkg::funcMfhi, 32'h0, 32'h0, 32'hffffffff, 1'b1);
        addOp("mflo after mult", hiloRead, exOpsPkg::funcMflo, 32'h0, 32'h0, 32'hfffffffa, 1'b1);
        addOp("multu", hiloSet, exOpsPkg::funcMultu, 32'hfffffffe, 32'h3, 32'hfffffffa, 1'b0);
        addOp("mfhi after multu", hiloRead, exOpsPkg::funcMfhi, 32'h0, 32'h0, 32'h2, 1'b1);
        addOp("mflo after multu", hiloRead, exOpsPkg::funcMflo, 32'h0, 32'h0, 32'hfffffffa, 1'b1);
        addOp("mthi", hiloSet, exOpsPkg::funcMthi, 32'h12345678, 32'h9, 32'hfffffffa, 1'b0);
        addOp("mtlo", hiloSet, exOpsPkg::funcMtlo, 32'h0badcafe, 32'h9, 32'hfffffffa, 1'b0);
        addOp("mfhi after mthi", hiloRead, exOpsPkg::funcMfhi, 32'h0, 32'h0, 32'h12345678, 1'b1);
        addOp("mflo after mtlo", hiloRead, exOpsPkg::funcMflo, 32'h0, 32'h0, 32'h0badcafe, 1'b1);
        // Accumulate from HI:LO = 0:6
        addOp("mult seed", hiloSet, exOpsPkg::funcMult, 32'h2, 32'h3, 32'h0badcafe, 1'b0);
        addOp("madd", mulAccum, exOpsPkg::funcMadd, 32'h4, 32'h5, 32'h6, 1'b0);
        addOp("madd negative", mulAccum, exOpsPkg::funcMadd, 32'hffffffff, 32'h30, 32'h1a, 1'b0);
        addOp("msub", mulAccum, exOpsPkg::funcMsub, 32'hfffffffe, 32'h10, 32'hffffffea, 1'b0);
        addOp("mul", mulRead, exOpsPkg::funcMul, 32'h7, 32'h6, 32'h2a, 1'b1);
        addOp("clz", mulRead, exOpsPkg::funcClz, 32'h00010000, 32'h0, 32'hf, 1'b1);
        addOp("clo", mulRead, exOpsPkg::funcClo, 32'hf0000000, 32'h0, 32'h4, 1'b1);
        addOp("mflo keeps acc", hiloRead, exOpsPkg::funcMflo, 32'h0, 32'h0, 32'ha, 1'b1);
        addOp("maddu", mulAccum, exOpsPkg::funcMaddu, 32'hffffffff, 32'h2, 32'ha, 1'b0);
        addOp("mfhi after maddu", hiloRead, exOpsPkg::funcMfhi, 32'h0, 32'h0, 32'h2, 1'b1);
        addOp("mflo after maddu", hiloRead, exOpsPkg::funcMflo, 32'h0, 32'h0, 32'h8, 1'b1);
        // Branches return pc + 8 and target pc + 4 + imm * 4
        addBranch("beq taken", brPlain, exOpsPkg::brEq, 32'h5, 32'h5, 32'h100, 32'h10,
                  32'h108, 1'b0, 1'b1, 32'h144);
        addBranch("bne not taken", brLink, exOpsPkg::brNe, 32'h5, 32'h5, 32'h200, 32'hfffffffc,
                  32'h208, 1'b0, 1'b0, 32'h1f4);
        addBranch("bltzal taken", brLink, exOpsPkg::brLtz, 32'h80000000, 32'h0, 32'h300, 32'h2,
                  32'h308, 1'b1, 1'b1, 32'h30c);
        addBranch("bgtz not taken", brPlain, exOpsPkg::brGtz, 32'h0, 32'h0, 32'h400, 32'h1,
                  32'h408, 1'b0, 1'b0, 32'h408);
        addBranch("blez taken", brPlain, exOpsPkg::brLez, 32'h0, 32'h0, 32'h500, 32'h0,
                  32'h508, 1'b0, 1'b1, 32'h504);
        addBranch("bgezal not taken", brLink, exOpsPkg::brGez, 32'hffffffff, 32'h0, 32'h600,
                  32'h3, 32'h608, 1'b0, 1'b0, 32'h610);
        addBranch("jalr", jmpLink, exOpsPkg::brEq, 32'h00400000, 32'h0, 32'h700, 32'h0,
                  32'h708, 1'b1, 1'b1, 32'h00400000);
        addBranch("jr", jmpPlain, exOpsPkg::brEq, 32'h1234, 32'h0, 32'h800, 32'h0,
                  32'h808, 1'b0, 1'b1, 32'h1234);
    endtask

    // ------------------------------------------------------------
    // Stimulus and result collection
    // ------------------------------------------------------------
    initial
    begin
        arstN    = 1'b0;
        inValid  = 1'b0;
        inReq    = '0;
        outReady = 1'b0;
        void'($urandom(49923));
        buildTable();
        fork
            begin
                repeat (10) @(posedge clk);
                arstN <= 1'b1;
                for (int i = 0; i < reqTab.size(); i++)
                begin
                    inValid <= 1'b1;
                    inReq   <= reqTab[i];
                    driveWait = 0;
                    do
                    begin
                        @(posedge clk);
                        driveWait++;
                        assert (driveWait <= waitLimit)
                        else stopWithFailure($sformatf("Timed out waiting for inReady on %s",
                                                       nameTab[i]));
                    end
                    while (!inReady);
                end
                inValid <= 1'b0;
            end
            begin
                for (int k = 0; k < expTab.size(); k++)
                begin
                    collectWait = 0;
                    gotIt       = 1'b0;
                    while (!gotIt)
                    begin
                        @(posedge clk);
                        if (outValid && outReady)
                        begin
                            assert (outRes == expTab[k])
                            else stopWithFailure($sformatf("FAILED %s expected %h actual %h",
                                                           nameTab[k], expTab[k], outRes));
                            gotIt = 1'b1;
                        end
                        else
                        begin
                            collectWait++;
                            assert (collectWait <= waitLimit)
                            else stopWithFailure($sformatf("No result arrived for %s",
                                                           nameTab[k]));
                        end
                        // Stall about a third of the time
                        outReady <= ($urandom % 3) != 0;
                    end
                end
                outReady <= 1'b1;
                repeat (5) @(posedge clk);
                assert (!outValid)
                else stopWithFailure("An extra result came out after the last table entry");
            end
        join
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
design/exOpsPkg.sv
design/exTypesPkg.sv
design/pipeStage.sv
design/exControl.sv
design/exAlu.sv
design/exMulAcc.sv
design/exBranch.sv
design/exStage.sv
bench/exStage_asserts.sv
bench/exStageTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module exStageTb -f all.f -o exStageSim

# Simulator status is not trusted, the log decides
./obj_dir/exStageSim | tee sim.log

if grep -q "^>>> PASS$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
